// ==== ddr3_pkg.sv ====
`default_nettype none

package ddr3_pkg;

    // ****************************************
    // widths
    // ****************************************

    // one burst index covers eight 16-bit columns
    localparam int BURST_AW = 24;
    // burst index plus three column bits
    localparam int APP_AW   = BURST_AW + 3;
    localparam int DATA_W   = 128;

    typedef logic [BURST_AW-1:0] burst_addr_t;
    typedef logic [APP_AW-1:0]   app_addr_t;
    typedef logic [BURST_AW-1:0] burst_cnt_t;
    typedef logic [DATA_W-1:0]   data_t;

    // controller command codes
    typedef enum logic [2:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } app_cmd_e;

    // ****************************************
    // port bundles
    // ****************************************

    // request from one path to the arbiter
    typedef struct packed {
        logic        req;
        burst_addr_t addr;
    } cmd_req_t;

    // address and command port toward the controller
    typedef struct packed {
        logic      en;
        app_cmd_e  cmd;
        app_addr_t addr;
    } app_cmd_bus_t;

    // write data port, single beat per burst
    typedef struct packed {
        logic  wren;
        logic  last;
        data_t data;
    } app_wdf_t;

    // one entry for the read FIFO
    typedef struct packed {
        data_t data;
        logic  last;
    } rd_beat_t;

    // path state machines
    typedef enum logic [1:0] {WR_IDLE, WR_POP, WR_BUSY} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_RUN, RD_DONE} rd_state_e;

endpackage

`default_nettype wire

// ==== ddr3_wr_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_wr_path
    import ddr3_pkg::*;
(
    input  wire logic  ddr3_domain_clk,
    input  wire logic  rst_n,
    input  wire logic  wr_en,
    input  wire logic  wr_fifo_empty,
    input  wire data_t wr_fifo_dat,
    input  wire logic  wr_grant,
    input  wire logic  app_wdf_rdy,
    output logic       wr_fifo_rd_en,
    output cmd_req_t   wr_req,
    output app_wdf_t   app_wdf
);

    wr_state_e   state;
    logic        req_q;
    logic        wren_q;
    data_t       wdat_q;
    burst_addr_t wr_addr;
    logic        req_next;
    logic        wren_next;

    // command drops on grant, data drops on acceptance
    assign req_next  = req_q & ~wr_grant;
    assign wren_next = wren_q & ~app_wdf_rdy;

    // ****************************************
    // write FSM
    // ****************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            state         <= WR_IDLE;
            wr_fifo_rd_en <= 1'b0;
            req_q         <= 1'b0;
            wren_q        <= 1'b0;
        end else begin
            // pop is a single-cycle strobe
            wr_fifo_rd_en <= 1'b0;
            case (state)
                WR_IDLE: begin
                    // word waiting and writing allowed
                    if (wr_en && !wr_fifo_empty) begin
                        wr_fifo_rd_en <= 1'b1;
                        state         <= WR_POP;
                    end
                end
                WR_POP: begin
                    // head word taken this cycle, raise both halves
                    req_q  <= 1'b1;
                    wren_q <= 1'b1;
                    state  <= WR_BUSY;
                end
                WR_BUSY: begin
                    req_q  <= req_next;
                    wren_q <= wren_next;
                    // one write in flight, wait for command and data
                    if (!req_next && !wren_next) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // data stage, loaded with the popped word
    always_ff @(posedge ddr3_domain_clk) begin
        if (state == WR_POP) begin
            wdat_q <= wr_fifo_dat;
        end
    end

    // burst address, restarts at zero whenever writing is off
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n || !wr_en) begin
            wr_addr <= '0;
        end else if (wr_grant) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    assign wr_req  = '{req: req_q, addr: wr_addr};
    // single beat, so last tracks wren
    assign app_wdf = '{wren: wren_q, last: wren_q, data: wdat_q};

endmodule

`default_nettype wire

// ==== ddr3_rd_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_rd_path
    import ddr3_pkg::*;
#(
    parameter int unsigned RD_MAX_OUTSTANDING = 4
)(
    input  wire logic        ddr3_domain_clk,
    input  wire logic        rst_n,
    input  wire logic        enable_reading,
    input  wire burst_addr_t rd_start_addr,
    input  wire burst_cnt_t  rd_burst_cnt,
    input  wire logic        rd_grant,
    input  wire data_t       app_rd_data,
    input  wire logic        app_rd_data_valid,
    input  wire logic        rd_fifo_almost_full,
    output cmd_req_t         rd_req,
    output logic             rd_fifo_wr_en,
    output rd_beat_t         rd_fifo_beat,
    output logic             reading_done
);

    localparam int unsigned OUT_W = $clog2(RD_MAX_OUTSTANDING + 1);

    rd_state_e        state;
    burst_addr_t      rd_addr;
    // commands still to issue
    burst_cnt_t       issue_left;
    // beats still to come back
    burst_cnt_t       beats_left;
    logic [OUT_W-1:0] outstanding;
    logic             room;
    data_t            dat_q;
    logic             last_q;

    // reads granted but not yet returned
    assign room = outstanding < OUT_W'(RD_MAX_OUTSTANDING);

    // ****************************************
    // read FSM and counters
    // ****************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            state       <= RD_IDLE;
            rd_addr     <= '0;
            issue_left  <= '0;
            beats_left  <= '0;
            outstanding <= '0;
        end else begin
            // in flight count, grant in and beat out
            if (rd_grant && !app_rd_data_valid) begin
                outstanding <= outstanding + 1'b1;
            end else if (!rd_grant && app_rd_data_valid && outstanding != '0) begin
                outstanding <= outstanding - 1'b1;
            end
            if (enable_reading) begin
                rd_addr    <= rd_start_addr;
                issue_left <= rd_burst_cnt;
                beats_left <= rd_burst_cnt;
                // empty request finishes at once
                state      <= (rd_burst_cnt == '0) ? RD_DONE : RD_RUN;
            end else begin
                if (rd_grant) begin
                    rd_addr    <= rd_addr + 1'b1;
                    issue_left <= issue_left - 1'b1;
                end
                if (app_rd_data_valid && beats_left != '0) begin
                    beats_left <= beats_left - 1'b1;
                end
                // done one cycle after the last beat is written
                if (state == RD_RUN && rd_fifo_wr_en && rd_fifo_beat.last) begin
                    state <= RD_DONE;
                end
            end
        end
    end

    // ****************************************
    // data forwarding
    // ****************************************

    // strobe follows valid by one cycle
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            rd_fifo_wr_en <= 1'b0;
        end else begin
            rd_fifo_wr_en <= app_rd_data_valid;
        end
    end

    // beat payload, last when this beat empties the count
    always_ff @(posedge ddr3_domain_clk) begin
        if (app_rd_data_valid) begin
            dat_q  <= app_rd_data;
            last_q <= (beats_left == burst_cnt_t'(1));
        end
    end

    // new requests stop on full FIFO or too many in flight
    assign rd_req.req   = (state == RD_RUN) && (issue_left != '0)
                        && !rd_fifo_almost_full && room;
    assign rd_req.addr  = rd_addr;
    assign rd_fifo_beat = '{data: dat_q, last: last_q};
    assign reading_done = (state == RD_DONE);

endmodule

`default_nettype wire

// ==== ddr3_cmd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_cmd_arbiter
    import ddr3_pkg::*;
(
    input  wire logic     ddr3_domain_clk,
    input  wire logic     rst_n,
    input  wire logic     wr_en,
    input  wire cmd_req_t wr_req,
    input  wire cmd_req_t rd_req,
    input  wire logic     app_rdy,
    output logic          wr_grant,
    output logic          rd_grant,
    output app_cmd_bus_t  app_cmd_bus
);

    logic      slot_en;
    app_cmd_e  slot_cmd;
    app_addr_t slot_addr;
    logic      slot_free;

    // slot empty, or its command goes out this cycle
    assign slot_free = !slot_en || app_rdy;

    // wr_en level decides who owns the port
    assign wr_grant = slot_free && wr_en && wr_req.req;
    assign rd_grant = slot_free && !wr_en && rd_req.req;

    // ****************************************
    // command slot
    // ****************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (!rst_n) begin
            slot_en <= 1'b0;
        end else if (wr_grant || rd_grant) begin
            slot_en <= 1'b1;
        end else if (app_rdy) begin
            // accepted with nothing behind it
            slot_en <= 1'b0;
        end
    end

    // command code and address of the taken request
    always_ff @(posedge ddr3_domain_clk) begin
        if (wr_grant) begin
            slot_cmd  <= CMD_WRITE;
            // burst index to column address
            slot_addr <= {wr_req.addr, 3'b000};
        end else if (rd_grant) begin
            slot_cmd  <= CMD_READ;
            slot_addr <= {rd_req.addr, 3'b000};
        end
    end

    // held steady until app_rdy with en
    assign app_cmd_bus = '{en: slot_en, cmd: slot_cmd, addr: slot_addr};

endmodule

`default_nettype wire

// ==== ddr3_app_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_app_ctrl
    import ddr3_pkg::*;
#(
    parameter int unsigned RD_MAX_OUTSTANDING = 4
)(
    input  wire logic        ddr3_domain_clk,
    input  wire logic        rst_n,
    // write side
    input  wire logic        wr_en,
    input  wire logic        wr_fifo_empty,
    input  wire data_t       wr_fifo_dat,
    output logic             wr_fifo_rd_en,
    // read side
    input  wire burst_addr_t rd_start_addr,
    input  wire burst_cnt_t  rd_burst_cnt,
    input  wire logic        enable_reading,
    output logic             reading_done,
    input  wire logic        rd_fifo_almost_full,
    output logic             rd_fifo_wr_en,
    output rd_beat_t         rd_fifo_beat,
    // controller application port
    input  wire logic        app_rdy,
    input  wire logic        app_wdf_rdy,
    input  wire data_t       app_rd_data,
    input  wire logic        app_rd_data_valid,
    output app_cmd_bus_t     app_cmd_bus,
    output app_wdf_t         app_wdf
);

    cmd_req_t wr_req;
    cmd_req_t rd_req;
    logic     wr_grant;
    logic     rd_grant;

    // ****************************************
    // write path, FIFO to write data port
    // ****************************************
    ddr3_wr_path i_wr_path (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n),
        .wr_en           (wr_en),
        .wr_fifo_empty   (wr_fifo_empty),
        .wr_fifo_dat     (wr_fifo_dat),
        .wr_grant        (wr_grant),
        .app_wdf_rdy     (app_wdf_rdy),
        .wr_fifo_rd_en   (wr_fifo_rd_en),
        .wr_req          (wr_req),
        .app_wdf         (app_wdf)
    );

    // read path, bursts back into the read FIFO
    ddr3_rd_path #(
        .RD_MAX_OUTSTANDING (RD_MAX_OUTSTANDING)
    ) i_rd_path (
        .ddr3_domain_clk     (ddr3_domain_clk),
        .rst_n               (rst_n),
        .enable_reading      (enable_reading),
        .rd_start_addr       (rd_start_addr),
        .rd_burst_cnt        (rd_burst_cnt),
        .rd_grant            (rd_grant),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .rd_fifo_almost_full (rd_fifo_almost_full),
        .rd_req              (rd_req),
        .rd_fifo_wr_en       (rd_fifo_wr_en),
        .rd_fifo_beat        (rd_fifo_beat),
        .reading_done        (reading_done)
    );

    // shared address and command port
    ddr3_cmd_arbiter i_cmd_arbiter (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n),
        .wr_en           (wr_en),
        .wr_req          (wr_req),
        .rd_req          (rd_req),
        .app_rdy         (app_rdy),
        .wr_grant        (wr_grant),
        .rd_grant        (rd_grant),
        .app_cmd_bus     (app_cmd_bus)
    );

endmodule

`default_nettype wire

// ==== tb_ddr3_app_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_app_ctrl;
    import ddr3_pkg::*;

    localparam int unsigned RD_MAX_OUTSTANDING = 4;

    // DUT inputs from the test process
    logic         ddr3_domain_clk = 1'b0;
    logic         rst_n;
    logic         wr_en;
    burst_addr_t  rd_start_addr;
    burst_cnt_t   rd_burst_cnt;
    logic         enable_reading;
    logic         rd_fifo_almost_full;
    // DUT inputs from the controller and FIFO model
    logic         wr_fifo_empty     = 1'b1;
    data_t        wr_fifo_dat       = '0;
    logic         app_rdy           = 1'b0;
    logic         app_wdf_rdy       = 1'b0;
    data_t        app_rd_data       = '0;
    logic         app_rd_data_valid = 1'b0;
    // DUT outputs
    logic         wr_fifo_rd_en;
    logic         reading_done;
    logic         rd_fifo_wr_en;
    rd_beat_t     rd_fifo_beat;
    app_cmd_bus_t app_cmd_bus;
    app_wdf_t     app_wdf;

    integer       seed = 32'hedb;
    int           test_errors  = 0;
    int           model_errors = 0;
    int           timeouts     = 0;
    logic         stall_en     = 1'b0;
    // controller model state
    int           cyc      = 0;
    int           last_due = 0;
    int           rd_acc   = 0;
    int           rd_ret   = 0;
    int           wr_stored = 0;
    int           fifo_rd_ptr = 0;
    logic         valid_d  = 1'b0;
    data_t        data_d   = '0;
    data_t        mem [0:63];
    data_t        exp_mem [0:63];
    // append-only logs that the tests read through base indices
    data_t        wr_words [$];
    app_cmd_bus_t cmd_log [$];
    data_t        wd_log [$];
    rd_beat_t     beat_q [$];
    burst_addr_t  wa_q [$];
    data_t        wd_q [$];
    burst_addr_t  rd_addr_q [$];
    int           rd_due_q [$];

    ddr3_app_ctrl #(.RD_MAX_OUTSTANDING(RD_MAX_OUTSTANDING)) i_dut (.*);

    always #4 ddr3_domain_clk = ~ddr3_domain_clk;

    // ****************************************
    // controller model and write FIFO
    // ****************************************
    always @(posedge ddr3_domain_clk) begin : ctrl_model
        logic        ret;
        data_t       ret_data;
        burst_addr_t ra;
        burst_addr_t wa;
        logic        rdy_s;
        logic        wdf_rdy_s;
        logic        empty_s;
        data_t       head_s;
        cyc++;
        if (rst_n) begin
            // acceptance is en with app_rdy
            if (app_cmd_bus.en && app_rdy) begin
                cmd_log.push_back(app_cmd_bus);
                if (app_cmd_bus.cmd == CMD_WRITE) begin
                    wa_q.push_back(app_cmd_bus.addr[APP_AW-1:3]);
                end else if (app_cmd_bus.cmd == CMD_READ) begin
                    rd_acc++;
                    rd_addr_q.push_back(app_cmd_bus.addr[APP_AW-1:3]);
                    // latency longer than the outstanding limit
                    last_due = (cyc + 6 > last_due + 1) ? cyc + 6 : last_due + 1;
                    rd_due_q.push_back(last_due);
                end else begin
                    model_errors++;
                    $display("unknown command code accepted on the command port");
                end
                if (rd_acc - rd_ret > RD_MAX_OUTSTANDING) begin
                    model_errors++;
                    $display("more reads outstanding than the limit allows");
                end
            end
            if (app_wdf.wren && app_wdf_rdy) begin
                if (app_wdf.last !== 1'b1) begin
                    model_errors++;
                    $display("FAILED app_wdf.last: got %h, expected 1", app_wdf.last);
                end
                wd_log.push_back(app_wdf.data);
                wd_q.push_back(app_wdf.data);
            end
            // pair command and data into the memory array
            if (wa_q.size() != 0 && wd_q.size() != 0) begin
                wa = wa_q.pop_front();
                mem[wa[5:0]] = wd_q.pop_front();
                wr_stored++;
            end
            if (wr_fifo_rd_en) begin
                if (fifo_rd_ptr >= wr_words.size()) begin
                    model_errors++;
                    $display("write FIFO popped while empty");
                end else begin
                    fifo_rd_ptr++;
                end
            end
            // beat must follow its valid by one cycle
            if (rd_fifo_wr_en !== valid_d) begin
                model_errors++;
                $display("FAILED rd_fifo_wr_en: got %h, expected %h", rd_fifo_wr_en, valid_d);
            end
            if (rd_fifo_wr_en) begin
                if (rd_fifo_beat.data !== data_d) begin
                    model_errors++;
                    $display("FAILED rd_fifo_beat.data: got %h, expected %h",
                             rd_fifo_beat.data, data_d);
                end
                beat_q.push_back(rd_fifo_beat);
            end
        end
        valid_d  = app_rd_data_valid;
        data_d   = app_rd_data;
        empty_s  = fifo_rd_ptr >= wr_words.size();
        head_s   = empty_s ? '0 : wr_words[fifo_rd_ptr];
        ret      = rd_due_q.size() != 0 && rd_due_q[0] == cyc;
        ret_data = '0;
        if (ret) begin
            ra = rd_addr_q.pop_front();
            void'(rd_due_q.pop_front());
            ret_data = mem[ra[5:0]];
        end
        rdy_s     = !stall_en || (($random(seed) & 3) != 0);
        wdf_rdy_s = !stall_en || (($random(seed) & 3) != 0);
        #1;
        wr_fifo_empty     = empty_s;
        wr_fifo_dat       = head_s;
        app_rdy           = rdy_s;
        app_wdf_rdy       = wdf_rdy_s;
        app_rd_data_valid = ret;
        app_rd_data       = ret_data;
        if (ret) begin
            rd_ret++;
        end
    end

    // ****************************************
    // helpers
    // ****************************************
    task automatic step();
        @(posedge ddr3_domain_clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        test_errors++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic wait_beats(input int n, input int limit);
        int t;
        t = 0;
        while (beat_q.size() < n && t < limit) begin
            step();
            t++;
        end
        if (beat_q.size() < n) begin
            timeouts++;
            $display("timed out waiting for read beats");
        end
    endtask

    task automatic wait_done(input int limit);
        int t;
        t = 0;
        while (!reading_done && t < limit) begin
            step();
            t++;
        end
        if (!reading_done) begin
            timeouts++;
            $display("timed out waiting for reading_done");
        end
    endtask

    task automatic wait_stored(input int n, input int limit);
        int t;
        t = 0;
        while (wr_stored < n && t < limit) begin
            step();
            t++;
        end
        if (wr_stored < n) begin
            timeouts++;
            $display("timed out waiting for writes to complete");
        end
    endtask

    // new words go to bursts 0 onward
    task automatic queue_words(input int n);
        data_t w;
        for (int i = 0; i < n; i++) begin
            w = {$random(seed), $random(seed), $random(seed), $random(seed)};
            wr_words.push_back(w);
            exp_mem[i] = w;
        end
    endtask

    task automatic start_read(input burst_addr_t addr, input burst_cnt_t cnt);
        rd_start_addr  = addr;
        rd_burst_cnt   = cnt;
        enable_reading = 1'b1;
        step();
        enable_reading = 1'b0;
    endtask

    task automatic check_writes(input int cbase, input int dbase, input int n);
        for (int i = 0; i < n && cbase + i < cmd_log.size(); i++) begin
            if (cmd_log[cbase+i].cmd !== CMD_WRITE) begin
                report_mismatch("app_cmd_bus.cmd", cmd_log[cbase+i].cmd, CMD_WRITE);
            end
            if (cmd_log[cbase+i].addr !== app_addr_t'(i * 8)) begin
                report_mismatch("app_cmd_bus.addr", cmd_log[cbase+i].addr, i * 8);
            end
        end
        for (int i = 0; i < n && dbase + i < wd_log.size(); i++) begin
            if (wd_log[dbase+i] !== exp_mem[i]) begin
                report_mismatch("app_wdf.data", wd_log[dbase+i], exp_mem[i]);
            end
        end
    endtask

    task automatic check_beats(input int base, input int first, input int n);
        for (int i = 0; i < n && base + i < beat_q.size(); i++) begin
            if (beat_q[base+i].data !== exp_mem[first+i]) begin
                report_mismatch("rd_fifo_beat.data", beat_q[base+i].data, exp_mem[first+i]);
            end
            if (beat_q[base+i].last !== (i == n - 1)) begin
                report_mismatch("rd_fifo_beat.last", beat_q[base+i].last, i == n - 1);
            end
        end
        if (beat_q.size() != base + n) begin
            test_errors++;
            $display("read returned the wrong number of beats");
        end
    endtask

    // ****************************************
    // directed tests
    // ****************************************
    task automatic check_reset_state();
        if (app_cmd_bus.en !== 1'b0) report_mismatch("app_cmd_bus.en", app_cmd_bus.en, 0);
        if (app_wdf.wren !== 1'b0) report_mismatch("app_wdf.wren", app_wdf.wren, 0);
        if (wr_fifo_rd_en !== 1'b0) report_mismatch("wr_fifo_rd_en", wr_fifo_rd_en, 0);
        if (rd_fifo_wr_en !== 1'b0) report_mismatch("rd_fifo_wr_en", rd_fifo_wr_en, 0);
        if (reading_done !== 1'b0) report_mismatch("reading_done", reading_done, 0);
    endtask

    task automatic write_eight_bursts();
        int cbase;
        int dbase;
        cbase    = cmd_log.size();
        dbase    = wd_log.size();
        stall_en = 1'b1;
        queue_words(8);
        step();
        wr_en = 1'b1;
        wait_stored(8, 400);
        wr_en = 1'b0;
        check_writes(cbase, dbase, 8);
    endtask

    task automatic read_five_bursts();
        int bbase;
        bbase = beat_q.size();
        start_read(24'd2, 24'd5);
        wait_beats(bbase + 5, 300);
        wait_done(50);
        check_beats(bbase, 2, 5);
        // done holds until the next start
        repeat (5) begin
            step();
            if (reading_done !== 1'b1) report_mismatch("reading_done", reading_done, 1);
        end
    endtask

    task automatic read_with_fifo_full();
        int bbase;
        int rbase;
        stall_en = 1'b0;
        bbase    = beat_q.size();
        start_read(24'd0, 24'd8);
        repeat (3) step();
        rd_fifo_almost_full = 1'b1;
        rbase = rd_acc;
        repeat (20) step();
        if (rd_acc - rbase > 1) begin
            test_errors++;
            $display("reads kept being accepted with the read FIFO almost full");
        end
        rd_fifo_almost_full = 1'b0;
        wait_beats(bbase + 8, 300);
        wait_done(50);
        check_beats(bbase, 0, 8);
    endtask

    task automatic read_during_write_owner();
        int bbase;
        int rbase;
        int cbase;
        int dbase;
        stall_en = 1'b1;
        wr_en    = 1'b1;
        rbase    = rd_acc;
        bbase    = beat_q.size();
        start_read(24'd4, 24'd3);
        repeat (15) step();
        if (rd_acc - rbase > 1) begin
            test_errors++;
            $display("reads were accepted while writes owned the port");
        end
        wr_en = 1'b0;
        wait_beats(bbase + 3, 300);
        wait_done(50);
        check_beats(bbase, 4, 3);
        // writes restart at burst zero
        cbase = cmd_log.size();
        dbase = wd_log.size();
        queue_words(2);
        step();
        wr_en = 1'b1;
        wait_stored(wr_stored + 2, 200);
        wr_en = 1'b0;
        check_writes(cbase, dbase, 2);
        bbase = beat_q.size();
        start_read(24'd0, 24'd2);
        wait_beats(bbase + 2, 200);
        wait_done(50);
        check_beats(bbase, 0, 2);
    endtask

    initial begin
        rst_n               = 1'b0;
        wr_en               = 1'b0;
        rd_start_addr       = '0;
        rd_burst_cnt        = '0;
        enable_reading      = 1'b0;
        rd_fifo_almost_full = 1'b0;
        // fill pattern carries the whole burst index
        for (int i = 0; i < 64; i++) begin
            mem[i]     = {4{32'hc0de_0000 | i}};
            exp_mem[i] = mem[i];
        end
        repeat (10) @(posedge ddr3_domain_clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        write_eight_bursts();
        read_five_bursts();
        read_with_fifo_full();
        read_during_write_owner();
        $display("errors: test %0d, model %0d, timeout %0d", test_errors, model_errors, timeouts);
        if (test_errors + model_errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
ddr3_pkg.sv
ddr3_wr_path.sv
ddr3_rd_path.sv
ddr3_cmd_arbiter.sv
ddr3_app_ctrl.sv
tb_ddr3_app_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_ddr3_app_ctrl
RTL_TOP   ?= ddr3_app_ctrl
FILELIST  ?= list.f
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
